/* hw/decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Datapath word
`define DATA_WIDTH 32

// Register file geometry
`define REG_ADDR_WIDTH 4
`define NUM_REGS 15  // r0..r14 stored
`define PC_REG 15    // Reads back PC+8

// Instruction field widths
`define COND_WIDTH 4
`define OP_WIDTH 2
`define FUNCT_WIDTH 6
`define IMM_FIELD_WIDTH 24

// Low immediate widths used by the extender
`define IMM8_WIDTH 8
`define IMM12_WIDTH 12

`endif

/* hw/decode_pkg.sv */
`include "decode_defines.svh"

package decode_pkg;

	// ALU operation passed to execute
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_AND = 2'b10,
		ALU_ORR = 2'b11
	} aluCtrl_e;

	// Immediate forms, code 2'b11 unused
	typedef enum logic [1:0] {
		IMM8  = 2'b00,  // Data processing
		IMM12 = 2'b01,  // LDR/STR offset
		IMM24 = 2'b10   // Branch offset, word aligned
	} immSrc_e;

	// Execute control, all zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memToReg;
		logic aluSrc;    // Immediate second operand
		logic branch;
		logic [1:0] flagWrite;  // [1] NZ, [0] CV
		aluCtrl_e aluControl;
		logic [`COND_WIDTH-1:0] cond;  // Evaluated in execute
	} execCtrl_t;

	// Operands and destination for execute
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] rd1;
		logic [`DATA_WIDTH-1:0] rd2;
		logic [`DATA_WIDTH-1:0] extImm;
		logic [`REG_ADDR_WIDTH-1:0] wa3;
	} execData_t;

endpackage

/* hw/controlUnit.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module controlUnit import decode_pkg::*; (
	input  logic [`OP_WIDTH-1:0]    op,
	input  logic [`FUNCT_WIDTH-1:0] funct,
	output execCtrl_t               ctrl,
	output logic [1:0]              regSrc,
	output immSrc_e                 immSrc
);

	localparam logic [`OP_WIDTH-1:0] OP_DATA   = 2'b00;
	localparam logic [`OP_WIDTH-1:0] OP_MEM    = 2'b01;
	localparam logic [`OP_WIDTH-1:0] OP_BRANCH = 2'b10;

	// Data processing commands
	localparam logic [3:0] CMD_AND = 4'b0000;
	localparam logic [3:0] CMD_SUB = 4'b0010;
	localparam logic [3:0] CMD_ADD = 4'b0100;
	localparam logic [3:0] CMD_ORR = 4'b1100;

	logic [3:0] cmd;
	logic immOp;
	logic setFlags;
	logic isLoad;

	assign immOp    = funct[5];    // I bit
	assign cmd      = funct[4:1];
	assign setFlags = funct[0];    // S bit
	assign isLoad   = funct[0];    // L bit for memory ops

	always_comb begin
		ctrl   = '0;
		regSrc = 2'b00;
		immSrc = IMM8;
		case (op)
			OP_DATA: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = immOp;
				case (cmd)
					CMD_AND: begin
						ctrl.aluControl = ALU_AND;
						ctrl.flagWrite  = {setFlags, 1'b0};  // Logic ops touch NZ only
					end
					CMD_SUB: begin
						ctrl.aluControl = ALU_SUB;
						ctrl.flagWrite  = {setFlags, setFlags};
					end
					CMD_ADD: begin
						ctrl.aluControl = ALU_ADD;
						ctrl.flagWrite  = {setFlags, setFlags};
					end
					CMD_ORR: begin
						ctrl.aluControl = ALU_ORR;
						ctrl.flagWrite  = {setFlags, 1'b0};
					end
					default: begin
						ctrl = '0;  // Unsupported command
					end
				endcase
			end
			OP_MEM: begin
				ctrl.aluSrc     = 1'b1;
				ctrl.aluControl = ALU_ADD;  // Base plus offset
				immSrc          = IMM12;
				if (isLoad) begin
					ctrl.regWrite = 1'b1;
					ctrl.memToReg = 1'b1;
				end else begin
					ctrl.memWrite = 1'b1;
					regSrc[1]     = 1'b1;  // Store data comes from Rd
				end
			end
			OP_BRANCH: begin
				ctrl.branch     = 1'b1;
				ctrl.aluSrc     = 1'b1;
				ctrl.aluControl = ALU_ADD;  // PC+8 plus offset
				immSrc          = IMM24;
				regSrc[0]       = 1'b1;
			end
			default: begin
				ctrl = '0;  // op 11 is a bubble
			end
		endcase
	end

endmodule

/* hw/registerFile.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module registerFile (
	input  logic                       Clk,
	input  logic                       we,
	input  logic [`REG_ADDR_WIDTH-1:0] ra1,
	input  logic [`REG_ADDR_WIDTH-1:0] ra2,
	input  logic [`REG_ADDR_WIDTH-1:0] wa3,
	input  logic [`DATA_WIDTH-1:0]     wd3,
	input  logic [`DATA_WIDTH-1:0]     pcPlus8,
	output logic [`DATA_WIDTH-1:0]     rd1,
	output logic [`DATA_WIDTH-1:0]     rd2
);

	localparam logic [`REG_ADDR_WIDTH-1:0] PC_ADDR = `PC_REG;

	logic [`DATA_WIDTH-1:0] regs [0:`NUM_REGS-1];  // r15 is not stored

	always_ff @(posedge Clk) begin
		if (we && (wa3 != PC_ADDR)) begin
			regs[wa3] <= wd3;
		end
	end

	// PC first, then bypass of the write in flight
	function automatic logic [`DATA_WIDTH-1:0] readPort(
		input logic [`REG_ADDR_WIDTH-1:0] ra
	);
		if (ra == PC_ADDR) begin
			return pcPlus8;
		end else if (we && (ra == wa3)) begin
			return wd3;
		end
		return regs[ra];
	endfunction

	always_comb begin
		rd1 = readPort(ra1);
		rd2 = readPort(ra2);
	end

endmodule

/* hw/immExtend.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module immExtend import decode_pkg::*; (
	input  logic [`IMM_FIELD_WIDTH-1:0] immField,
	input  immSrc_e                     immSrc,
	output logic [`DATA_WIDTH-1:0]      extImm
);

	localparam int SIGN_BITS = `DATA_WIDTH - `IMM_FIELD_WIDTH - 2;

	always_comb begin
		case (immSrc)
			IMM8: begin
				extImm = {{(`DATA_WIDTH-`IMM8_WIDTH){1'b0}}, immField[`IMM8_WIDTH-1:0]};
			end
			IMM12: begin
				extImm = {{(`DATA_WIDTH-`IMM12_WIDTH){1'b0}}, immField[`IMM12_WIDTH-1:0]};
			end
			IMM24: begin
				// Word offset, sign extended and scaled by 4
				extImm = {{SIGN_BITS{immField[`IMM_FIELD_WIDTH-1]}}, immField, 2'b00};
			end
			default: begin
				extImm = '0;
			end
		endcase
	end

endmodule

/* hw/stageRegister.sv */
`timescale 1ns/1ps

module stageRegister #(
	parameter type payload_t = logic
) (
	input  logic     Clk,
	input  logic     rstN,
	input  logic     stall,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Reset, then flush, then stall, then load
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;  // Wins over stall
		end else if (!stall) begin
			q <= d;
		end
	end

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module decodeStage import decode_pkg::*; (
	input  logic                       Clk,
	input  logic                       rstN,
	input  logic [`DATA_WIDTH-1:0]     instr,
	input  logic [`DATA_WIDTH-1:0]     pcPlus8,
	input  logic                       regWriteW,
	input  logic [`REG_ADDR_WIDTH-1:0] wa3W,
	input  logic [`DATA_WIDTH-1:0]     resultW,
	input  logic                       stallE,
	input  logic                       flushE,
	output execCtrl_t                  ctrlE,
	output execData_t                  dataE
);

	localparam logic [`REG_ADDR_WIDTH-1:0] PC_ADDR = `PC_REG;

	logic [`COND_WIDTH-1:0]      cond;
	logic [`OP_WIDTH-1:0]        op;
	logic [`FUNCT_WIDTH-1:0]     funct;
	logic [`REG_ADDR_WIDTH-1:0]  rn;
	logic [`REG_ADDR_WIDTH-1:0]  rd;
	logic [`REG_ADDR_WIDTH-1:0]  rm;
	logic [`IMM_FIELD_WIDTH-1:0] immField;

	execCtrl_t                  ctrlDecoded;
	execCtrl_t                  ctrlD;
	execData_t                  dataD;
	logic [1:0]                 regSrc;
	immSrc_e                    immSrc;
	logic [`REG_ADDR_WIDTH-1:0] ra1;
	logic [`REG_ADDR_WIDTH-1:0] ra2;
	logic [`DATA_WIDTH-1:0]     rd1;
	logic [`DATA_WIDTH-1:0]     rd2;
	logic [`DATA_WIDTH-1:0]     extImm;

	// Instruction fields
	assign cond     = instr[31:28];
	assign op       = instr[27:26];
	assign funct    = instr[25:20];
	assign rn       = instr[19:16];
	assign rd       = instr[15:12];
	assign rm       = instr[3:0];
	assign immField = instr[23:0];

	// Read address selects
	assign ra1 = regSrc[0] ? PC_ADDR : rn;  // Branch base is PC+8
	assign ra2 = regSrc[1] ? rd : rm;       // Store data register

	controlUnit u_controlUnit (
		.op     (op),
		.funct  (funct),
		.ctrl   (ctrlDecoded),
		.regSrc (regSrc),
		.immSrc (immSrc)
	);

	registerFile u_registerFile (
		.Clk     (Clk),
		.we      (regWriteW),
		.ra1     (ra1),
		.ra2     (ra2),
		.wa3     (wa3W),
		.wd3     (resultW),
		.pcPlus8 (pcPlus8),
		.rd1     (rd1),
		.rd2     (rd2)
	);

	immExtend u_immExtend (
		.immField (immField),
		.immSrc   (immSrc),
		.extImm   (extImm)
	);

	always_comb begin
		ctrlD        = ctrlDecoded;
		ctrlD.cond   = cond;  // Checked later in execute
		dataD.rd1    = rd1;
		dataD.rd2    = rd2;
		dataD.extImm = extImm;
		dataD.wa3    = rd;
	end

	stageRegister #(.payload_t(execCtrl_t)) u_ctrlReg (
		.Clk   (Clk),
		.rstN  (rstN),
		.stall (stallE),
		.flush (flushE),
		.d     (ctrlD),
		.q     (ctrlE)
	);

	// Data is left alone on a flush, the bubble control masks it
	stageRegister #(.payload_t(execData_t)) u_dataReg (
		.Clk   (Clk),
		.rstN  (rstN),
		.stall (stallE),
		.flush (1'b0),
		.d     (dataD),
		.q     (dataE)
	);

endmodule

/* verif/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic Clk,
	output logic rstN
);

	initial begin
		Clk = 1'b0;
		forever #(PERIOD / 2) Clk = ~Clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clk);
		rstN <= 1'b1;  // Released on an edge like the other inputs
	end

endmodule

/* verif/decodeStage_chk.sv */
`timescale 1ns/1ps

module decodeStage_chk import decode_pkg::*; (
	input logic      Clk,
	input logic      rstN,
	input logic      stallE,
	input logic      flushE,
	input execCtrl_t ctrlE,
	input execData_t dataE
);

	// Reset leaves a bubble in execute
	resetClearsCtrl: assert property (@(posedge Clk) !rstN |=> ctrlE == '0)
		else $error("ctrlE is not a bubble in the cycle after reset");

	flushClearsCtrl: assert property (
		@(posedge Clk) disable iff (!rstN) flushE |=> ctrlE == '0
	) else $error("ctrlE is not a bubble in the cycle after a flush");

	// Flush wins over stall, so only a plain stall must hold
	stallHoldsOutputs: assert property (
		@(posedge Clk) disable iff (!rstN)
		stallE && !flushE |=> $stable(ctrlE) && $stable(dataE)
	) else $error("Stage outputs changed during a stall");

endmodule

/* verif/decodeStage_tb.sv */
`timescale 1ns/1ps
`include "decode_defines.svh"

module decodeStage_tb import decode_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_INSTR    = 83;  // Writes and decoded instructions over all tests
	localparam int TIMEOUT_NS   = NUM_INSTR * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

	// ARM data processing command codes
	localparam logic [3:0] CMD_AND = 4'b0000;
	localparam logic [3:0] CMD_EOR = 4'b0001;  // Not supported by the stage
	localparam logic [3:0] CMD_SUB = 4'b0010;
	localparam logic [3:0] CMD_ADD = 4'b0100;
	localparam logic [3:0] CMD_ORR = 4'b1100;
	localparam logic [3:0] AL      = 4'hE;

	logic                       Clk;
	logic                       rstN;
	logic [`DATA_WIDTH-1:0]     instr;
	logic [`DATA_WIDTH-1:0]     pcPlus8;
	logic                       regWriteW;
	logic [`REG_ADDR_WIDTH-1:0] wa3W;
	logic [`DATA_WIDTH-1:0]     resultW;
	logic                       stallE;
	logic                       flushE;
	execCtrl_t                  ctrlE;
	execData_t                  dataE;

	logic [`DATA_WIDTH-1:0] shadow [0:`NUM_REGS-1];  // Expected register contents
	logic [31:0]            rngState;
	int                     mismatchCount;
	int                     otherCount;
	execCtrl_t              lastCtrl;
	execData_t              lastData;

	clockGen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clockGen (
		.Clk  (Clk),
		.rstN (rstN)
	);

	decodeStage DUT (
		.Clk       (Clk),
		.rstN      (rstN),
		.instr     (instr),
		.pcPlus8   (pcPlus8),
		.regWriteW (regWriteW),
		.wa3W      (wa3W),
		.resultW   (resultW),
		.stallE    (stallE),
		.flushE    (flushE),
		.ctrlE     (ctrlE),
		.dataE     (dataE)
	);

	bind decodeStage decodeStage_chk u_chk (
		.Clk    (Clk),
		.rstN   (rstN),
		.stallE (stallE),
		.flushE (flushE),
		.ctrlE  (ctrlE),
		.dataE  (dataE)
	);

	// xorshift32
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic logic [31:0] encodeDp(input logic [3:0] cond, input logic immOp,
			input logic [3:0] cmd, input logic s, input logic [3:0] rn,
			input logic [3:0] rd, input logic [11:0] src2);
		return {cond, 2'b00, immOp, cmd, s, rn, rd, src2};
	endfunction

	function automatic logic [31:0] encodeMem(input logic [3:0] cond, input logic load,
			input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] offset);
		return {cond, 2'b01, 1'b0, 4'b1100, load, rn, rd, offset};
	endfunction

	function automatic logic [31:0] encodeBranch(input logic [3:0] cond,
			input logic [23:0] offset);
		return {cond, 2'b10, 2'b10, offset};
	endfunction

	// Reference decode of the execute control
	function automatic execCtrl_t modelCtrl(input logic [31:0] i);
		execCtrl_t e;
		logic [3:0] cmd;
		logic       s;
		e      = '0;
		cmd    = i[24:21];
		s      = i[20];
		e.cond = i[31:28];
		case (i[27:26])
			2'b00: begin
				if (cmd == CMD_AND || cmd == CMD_SUB || cmd == CMD_ADD || cmd == CMD_ORR) begin
					e.regWrite = 1'b1;
					e.aluSrc   = i[25];
					case (cmd)
						CMD_AND: e.aluControl = ALU_AND;
						CMD_SUB: e.aluControl = ALU_SUB;
						CMD_ORR: e.aluControl = ALU_ORR;
						default: e.aluControl = ALU_ADD;
					endcase
					// Arithmetic sets all four flags, logic only NZ
					e.flagWrite = (cmd == CMD_ADD || cmd == CMD_SUB) ? {s, s} : {s, 1'b0};
				end
			end
			2'b01: begin
				e.aluSrc     = 1'b1;
				e.aluControl = ALU_ADD;
				e.regWrite   = i[20];
				e.memToReg   = i[20];
				e.memWrite   = !i[20];
			end
			2'b10: begin
				e.branch     = 1'b1;
				e.aluSrc     = 1'b1;
				e.aluControl = ALU_ADD;
			end
			default: ;
		endcase
		return e;
	endfunction

	function automatic logic [31:0] modelRead(input logic [3:0] ra, input logic [31:0] pc,
			input logic we, input logic [3:0] wa, input logic [31:0] wd);
		if (ra == 4'd15) begin
			return pc;
		end
		if (we && wa == ra) begin
			return wd;
		end
		return shadow[ra];
	endfunction

	function automatic execData_t modelData(input logic [31:0] i, input logic [31:0] pc,
			input logic we, input logic [3:0] wa, input logic [31:0] wd);
		execData_t  e;
		logic [3:0] ra1;
		logic [3:0] ra2;
		ra1 = (i[27:26] == 2'b10) ? 4'd15 : i[19:16];
		ra2 = (i[27:26] == 2'b01 && !i[20]) ? i[15:12] : i[3:0];  // Store reads Rd
		e.rd1 = modelRead(ra1, pc, we, wa, wd);
		e.rd2 = modelRead(ra2, pc, we, wa, wd);
		case (i[27:26])
			2'b01:   e.extImm = {20'd0, i[11:0]};
			2'b10:   e.extImm = {{6{i[23]}}, i[23:0], 2'b00};
			default: e.extImm = {24'd0, i[7:0]};
		endcase
		e.wa3 = i[15:12];
		return e;
	endfunction

	task automatic compareCtrl(input execCtrl_t got, input execCtrl_t exp, input string msg);
		if ($isunknown(got)) begin
			otherCount++;
			$display("ctrlE has unknown bits at %0d ns during %s", $time, msg);
		end else if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch at %0d ns: %s ctrlE %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic compareData(input execData_t got, input execData_t exp, input string msg);
		if ($isunknown(got)) begin
			otherCount++;
			$display("dataE has unknown bits at %0d ns during %s", $time, msg);
		end else if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch at %0d ns: %s dataE %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic writeReg(input logic [3:0] addr, input logic [31:0] value);
		@(posedge Clk);
		regWriteW <= 1'b1;
		wa3W      <= addr;
		resultW   <= value;
		@(posedge Clk);
		regWriteW <= 1'b0;
		if (addr != 4'd15) begin
			shadow[addr] = value;
		end
	endtask

	// One instruction through the stage with an optional writeback in the same cycle
	task automatic issue(input logic [31:0] i, input logic we, input logic [3:0] wa,
			input logic [31:0] wd, input string msg);
		logic [31:0] pc;
		pc = nextRand();
		@(posedge Clk);
		instr     <= i;
		pcPlus8   <= pc;
		regWriteW <= we;
		wa3W      <= wa;
		resultW   <= wd;
		stallE    <= 1'b0;
		flushE    <= 1'b0;
		lastCtrl = modelCtrl(i);
		lastData = modelData(i, pc, we, wa, wd);
		@(posedge Clk);
		if (we && wa != 4'd15) begin
			shadow[wa] = wd;
		end
		@(negedge Clk);
		compareCtrl(ctrlE, lastCtrl, msg);
		compareData(dataE, lastData, msg);
	endtask

	task automatic readCheck(input logic [31:0] i, input string msg);
		issue(i, 1'b0, 4'd0, 32'd0, msg);
	endtask

	// New instruction under stall or flush and the data it would carry
	task automatic pulse(input logic [31:0] i, input logic stall, input logic flush,
			output execData_t newData);
		logic [31:0] pc;
		pc = nextRand();
		@(posedge Clk);
		instr     <= i;
		pcPlus8   <= pc;
		regWriteW <= 1'b0;
		stallE    <= stall;
		flushE    <= flush;
		newData = modelData(i, pc, 1'b0, 4'd0, 32'd0);
		@(posedge Clk);
		@(negedge Clk);
	endtask

	task automatic testResetAndReadback();
		int r;
		wait (rstN === 1'b1);
		@(negedge Clk);
		compareCtrl(ctrlE, '0, "after reset");
		compareData(dataE, '0, "after reset");
		for (r = 0; r < `NUM_REGS; r++) begin
			writeReg(4'(r), nextRand());
		end
		for (r = 0; r < `NUM_REGS; r++) begin
			readCheck(encodeDp(AL, 1'b0, CMD_ADD, 1'b0, 4'(r), 4'(r), {8'd0, 4'(14 - r)}),
				"register readback");
		end
	endtask

	task automatic testWriteThrough();
		int r;
		issue(encodeDp(AL, 1'b0, CMD_ADD, 1'b0, 4'd3, 4'd1, 12'd3), 1'b1, 4'd3, nextRand(),
			"write-through");
		issue(encodeDp(AL, 1'b0, CMD_SUB, 1'b0, 4'd6, 4'd1, 12'd3), 1'b1, 4'd9, nextRand(),
			"write to another register");
		issue(encodeDp(AL, 1'b0, CMD_ORR, 1'b0, 4'd15, 4'd2, 12'd15), 1'b1, 4'd15, nextRand(),
			"r15 read during r15 write");
		for (r = 0; r < `NUM_REGS; r++) begin
			readCheck(encodeDp(AL, 1'b0, CMD_AND, 1'b0, 4'(r), 4'd0, 12'd15),
				"readback after r15 write");
		end
	endtask

	task automatic testControlDecode();
		logic [3:0]  cmds [4];
		logic [31:0] rnd;
		int c;
		int imm;
		int s;
		cmds = '{CMD_AND, CMD_SUB, CMD_ADD, CMD_ORR};
		for (c = 0; c < 4; c++) begin
			for (imm = 0; imm < 2; imm++) begin
				for (s = 0; s < 2; s++) begin
					rnd = nextRand();
					readCheck(encodeDp(rnd[31:28], 1'(imm), cmds[c], 1'(s), rnd[19:16],
						rnd[15:12], rnd[11:0]), "data processing decode");
				end
			end
		end
		rnd = nextRand();
		readCheck(encodeMem(rnd[31:28], 1'b1, rnd[19:16], rnd[15:12], rnd[11:0]), "LDR decode");
		rnd = nextRand();
		readCheck(encodeMem(rnd[31:28], 1'b0, rnd[19:16], rnd[15:12], rnd[11:0]), "STR decode");
		rnd = nextRand();
		readCheck(encodeBranch(rnd[31:28], rnd[23:0]), "B decode");
		rnd = nextRand();
		readCheck({rnd[31:28], 2'b11, rnd[25:0]}, "op 11 bubble");
		rnd = nextRand();
		readCheck(encodeDp(rnd[31:28], 1'b0, CMD_EOR, 1'b1, rnd[19:16], rnd[15:12], rnd[11:0]),
			"unsupported command");
	endtask

	task automatic testOperands();
		readCheck(encodeMem(AL, 1'b0, 4'd2, 4'd9, 12'hABC), "store data from Rd");
		readCheck(encodeMem(AL, 1'b1, 4'd4, 4'd7, 12'hFFF), "load offset");
		readCheck(encodeDp(AL, 1'b1, CMD_ADD, 1'b0, 4'd5, 4'd6, 12'hF5A), "imm8 operand");
		readCheck(encodeBranch(AL, 24'h000010), "forward branch");
		readCheck(encodeBranch(AL, 24'hFFFFF0), "backward branch");
	endtask

	task automatic testStallFlush();
		execCtrl_t heldCtrl;
		execData_t heldData;
		execData_t newData;
		readCheck(encodeDp(AL, 1'b0, CMD_ADD, 1'b1, 4'd1, 4'd2, 12'd3), "before stall");
		heldCtrl = lastCtrl;
		heldData = lastData;
		repeat (2) begin
			pulse(nextRand(), 1'b1, 1'b0, newData);
			compareCtrl(ctrlE, heldCtrl, "stall hold");
			compareData(dataE, heldData, "stall hold");
		end
		readCheck(encodeMem(AL, 1'b1, 4'd8, 4'd10, 12'h123), "after stall");
		readCheck(encodeDp(AL, 1'b1, CMD_SUB, 1'b1, 4'd11, 4'd12, 12'h0C3), "before flush");
		// The data register has no flush and loads as usual
		pulse(encodeMem(AL, 1'b0, 4'd13, 4'd14, 12'h456), 1'b0, 1'b1, newData);
		compareCtrl(ctrlE, '0, "flush");
		compareData(dataE, newData, "flush");
		readCheck(encodeBranch(AL, 24'h800001), "before flush with stall");
		heldData = lastData;
		pulse(encodeDp(AL, 1'b0, CMD_ORR, 1'b0, 4'd0, 4'd1, 12'd2), 1'b1, 1'b1, newData);
		compareCtrl(ctrlE, '0, "flush with stall");
		compareData(dataE, heldData, "flush with stall");
		readCheck(encodeDp(AL, 1'b0, CMD_AND, 1'b1, 4'd2, 4'd3, 12'd4), "after flush");
	endtask

	initial begin
		rngState      = 32'd36249;
		mismatchCount = 0;
		otherCount    = 0;
		instr     <= '0;
		pcPlus8   <= '0;
		regWriteW <= 1'b0;
		wa3W      <= '0;
		resultW   <= '0;
		stallE    <= 1'b0;
		flushE    <= 1'b0;
		testResetAndReadback();
		testWriteThrough();
		testControlDecode();
		testOperands();
		testStallFlush();
		$display("Errors: %0d mismatches, %0d other", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		otherCount++;
		$display("Watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
		$display("Errors: %0d mismatches, %0d other", mismatchCount, otherCount);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
hw/decode_pkg.sv
hw/controlUnit.sv
hw/registerFile.sv
hw/immExtend.sv
hw/stageRegister.sv
hw/decodeStage.sv
verif/clockGen.sv
verif/decodeStage_chk.sv
verif/decodeStage_tb.sv
